// File: verilog/mips_pkg.sv
package mips_pkg;

    localparam logic [31:0] reset_vector = 32'hBFC0_0000;
    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    localparam int num_regs = 32;
    localparam logic [4:0] reg_v0 = 5'd2;
    localparam logic [4:0] reg_ra = 5'd31;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j = 6'h02;
    localparam logic [5:0] op_jal = 6'h03;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti = 6'h0A;
    localparam logic [5:0] op_andi = 6'h0C;
    localparam logic [5:0] op_ori = 6'h0D;
    localparam logic [5:0] op_xori = 6'h0E;
    localparam logic [5:0] op_lui = 6'h0F;
    localparam logic [5:0] op_lb = 6'h20;
    localparam logic [5:0] op_lh = 6'h21;
    localparam logic [5:0] op_lw = 6'h23;
    localparam logic [5:0] op_lbu = 6'h24;
    localparam logic [5:0] op_lhu = 6'h25;
    localparam logic [5:0] op_sb = 6'h28;
    localparam logic [5:0] op_sh = 6'h29;
    localparam logic [5:0] op_sw = 6'h2B;

    // funct codes under op_special
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_jr = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_mfhi = 6'h10;
    localparam logic [5:0] fn_mflo = 6'h12;
    localparam logic [5:0] fn_mult = 6'h18;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2A;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rfields_t;

    // low half is either r-type fields or the immediate
    typedef union packed {
        rfields_t r;
        logic [15:0] imm;
    } instr_low_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        instr_low_t low;
    } instr_t;

    typedef struct packed {
        logic [31:0] address;
        logic read;
        logic write;
        logic [31:0] writedata;
    } mem_req_t;

endpackage

// File: verilog/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile import mips_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic [4:0] read_index_a,
    input logic [4:0] read_index_b,
    input logic write_enable,
    input logic [4:0] write_index,
    input logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (clk_enable && write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // $zero always reads back as zero
    assign read_data_a = (read_index_a == 5'd0) ? 32'b0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? 32'b0 : regs[read_index_b];

    assign register_v0 = regs[reg_v0];

endmodule

// File: verilog/mips_alu.sv
`timescale 1ns/10ps

module mips_alu import mips_pkg::*; (
    input instr_t instr,
    input logic [31:0] op_a,
    input logic [31:0] op_b,
    output logic [31:0] result,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic [31:0] eff_addr,
    output logic branch_taken
);

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic signed_mul;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [63:0] product;

    assign imm_sext = {{16{instr.low.imm[15]}}, instr.low.imm};
    assign imm_zext = {16'b0, instr.low.imm};

    // one 33x33 signed multiplier covers both mult and multu
    assign signed_mul = (instr.low.r.funct == fn_mult);
    assign mul_a = {signed_mul & op_a[31], op_a};
    assign mul_b = {signed_mul & op_b[31], op_b};
    assign product = mul_a * mul_b;
    assign hi = product[63:32];
    assign lo = product[31:0];

    // base plus offset for loads and stores
    assign eff_addr = op_a + imm_sext;

    always_comb begin
        result = 32'b0;
        if (instr.opcode == op_special) begin
            case (instr.low.r.funct)
                fn_add: result = op_a + op_b;
                fn_sub: result = op_a - op_b;
                fn_and: result = op_a & op_b;
                fn_or: result = op_a | op_b;
                fn_xor: result = op_a ^ op_b;
                fn_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
                fn_sll: result = op_b << instr.low.r.shamt;
                fn_srl: result = op_b >> instr.low.r.shamt;
                default: result = 32'b0;
            endcase
        end else begin
            case (instr.opcode)
                op_addiu: result = op_a + imm_sext;
                op_slti: result = {31'b0, $signed(op_a) < $signed(imm_sext)};
                op_andi: result = op_a & imm_zext;
                op_ori: result = op_a | imm_zext;
                op_xori: result = op_a ^ imm_zext;
                op_lui: result = {instr.low.imm, 16'b0};
                default: result = 32'b0;
            endcase
        end
    end

    always_comb begin
        case (instr.opcode)
            op_beq: branch_taken = (op_a == op_b);
            op_bne: branch_taken = (op_a != op_b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: verilog/mips_load_store.sv
`timescale 1ns/10ps

module mips_load_store import mips_pkg::*; (
    input instr_t instr,
    input logic [31:0] eff_addr,
    input logic [31:0] mem_word,
    input logic [31:0] reg_word,
    output logic [31:0] load_data,
    output logic [31:0] store_data
);

    logic [1:0] offset;
    logic [7:0] load_byte;
    logic [15:0] load_half;

    assign offset = eff_addr[1:0];

    // big-endian lanes, byte 0 is the top byte
    always_comb begin
        case (offset)
            2'd0: load_byte = mem_word[31:24];
            2'd1: load_byte = mem_word[23:16];
            2'd2: load_byte = mem_word[15:8];
            default: load_byte = mem_word[7:0];
        endcase
    end

    assign load_half = offset[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (instr.opcode)
            op_lb: load_data = {{24{load_byte[7]}}, load_byte};
            op_lbu: load_data = {24'b0, load_byte};
            op_lh: load_data = {{16{load_half[15]}}, load_half};
            op_lhu: load_data = {16'b0, load_half};
            default: load_data = mem_word;
        endcase
    end

    // partial stores patch the word read in fetch
    always_comb begin
        store_data = reg_word;
        if (instr.opcode == op_sb) begin
            store_data = mem_word;
            case (offset)
                2'd0: store_data[31:24] = reg_word[7:0];
                2'd1: store_data[23:16] = reg_word[7:0];
                2'd2: store_data[15:8] = reg_word[7:0];
                default: store_data[7:0] = reg_word[7:0];
            endcase
        end else if (instr.opcode == op_sh) begin
            store_data = mem_word;
            if (offset[1]) begin
                store_data[15:0] = reg_word[15:0];
            end else begin
                store_data[31:16] = reg_word[15:0];
            end
        end
    end

endmodule

// File: verilog/harvard_memory.sv
`timescale 1ns/10ps

module harvard_memory import mips_pkg::*; #(
    parameter int depth = dmem_words
) (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic [31:0] address,
    input logic write,
    input logic [31:0] writedata,
    output logic [31:0] readdata
);

    localparam int index_bits = $clog2(depth);

    logic [31:0] mem [depth];
    logic [index_bits-1:0] index;

    // word index, byte offset bits dropped
    assign index = address[index_bits+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= 32'b0;
            end
        end else if (enable && write) begin
            mem[index] <= writedata;
        end
    end

    assign readdata = mem[index];

endmodule

// File: verilog/mips_cpu_harvard.sv
`timescale 1ns/10ps

module mips_cpu_harvard import mips_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic [31:0] instr_readdata,
    input logic [31:0] data_readdata,
    output logic active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    output mem_req_t data_req
);

    instr_t instr;

    logic r_format;
    logic is_mult;
    logic is_mfhi;
    logic is_mflo;
    logic is_jr;
    logic is_jalr;
    logic is_jump_imm;
    logic is_jal;
    logic is_load;
    logic is_store;
    logic partial_store;
    logic alu_imm;
    logic rtype_write;
    logic reg_write;

    logic [31:0] reg_a_data;
    logic [31:0] reg_b_data;
    logic reg_write_enable;
    logic [4:0] reg_write_index;
    logic [31:0] reg_write_data;

    logic [31:0] alu_result;
    logic [31:0] mul_hi;
    logic [31:0] mul_lo;
    logic [31:0] eff_addr;
    logic branch_taken;
    logic [31:0] load_data;
    logic [31:0] store_data;

    // fetch is 0, execute is 1
    logic state;
    logic [31:0] pc;
    logic [31:0] delay_slot;
    logic [31:0] next_delay_slot;
    logic [31:0] branch_offset;
    logic [31:0] hi_reg;
    logic [31:0] lo_reg;

    assign instr = instr_t'(instr_readdata);

    // decode
    assign r_format = (instr.opcode == op_special);
    assign is_mult = r_format && (instr.low.r.funct == fn_mult || instr.low.r.funct == fn_multu);
    assign is_mfhi = r_format && (instr.low.r.funct == fn_mfhi);
    assign is_mflo = r_format && (instr.low.r.funct == fn_mflo);
    assign is_jr = r_format && (instr.low.r.funct == fn_jr);
    assign is_jalr = r_format && (instr.low.r.funct == fn_jalr);
    assign is_jal = (instr.opcode == op_jal);
    assign is_jump_imm = (instr.opcode == op_j) || is_jal;
    assign is_load = (instr.opcode == op_lb) || (instr.opcode == op_lbu) ||
                     (instr.opcode == op_lh) || (instr.opcode == op_lhu) ||
                     (instr.opcode == op_lw);
    assign partial_store = (instr.opcode == op_sb) || (instr.opcode == op_sh);
    assign is_store = partial_store || (instr.opcode == op_sw);
    assign alu_imm = (instr.opcode == op_addiu) || (instr.opcode == op_slti) ||
                     (instr.opcode == op_andi) || (instr.opcode == op_ori) ||
                     (instr.opcode == op_xori) || (instr.opcode == op_lui);

    always_comb begin
        case (instr.low.r.funct)
            fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_slt,
            fn_sll, fn_srl, fn_mfhi, fn_mflo, fn_jalr: rtype_write = 1'b1;
            default: rtype_write = 1'b0;
        endcase
    end

    assign reg_write = (r_format && rtype_write) || alu_imm || is_load || is_jal;

    // write-back
    assign reg_write_index = is_jal ? reg_ra : (r_format ? instr.low.r.rd : instr.rt);
    assign reg_write_enable = active && state && reg_write && (reg_write_index != 5'd0);

    always_comb begin
        if (is_jal || is_jalr) begin
            reg_write_data = delay_slot + 32'd4;
        end else if (is_mfhi) begin
            reg_write_data = hi_reg;
        end else if (is_mflo) begin
            reg_write_data = lo_reg;
        end else if (is_load) begin
            reg_write_data = load_data;
        end else begin
            reg_write_data = alu_result;
        end
    end

    mips_regfile regfile (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .read_index_a(instr.rs),
        .read_index_b(instr.rt),
        .write_enable(reg_write_enable),
        .write_index(reg_write_index),
        .write_data(reg_write_data),
        .read_data_a(reg_a_data),
        .read_data_b(reg_b_data),
        .register_v0(register_v0)
    );

    mips_alu alu (
        .instr(instr),
        .op_a(reg_a_data),
        .op_b(reg_b_data),
        .result(alu_result),
        .hi(mul_hi),
        .lo(mul_lo),
        .eff_addr(eff_addr),
        .branch_taken(branch_taken)
    );

    mips_load_store load_store (
        .instr(instr),
        .eff_addr(eff_addr),
        .mem_word(data_readdata),
        .reg_word(reg_b_data),
        .load_data(load_data),
        .store_data(store_data)
    );

    // sb and sh read the old word in fetch
    assign data_req.address = {eff_addr[31:2], 2'b00};
    assign data_req.read = is_load || (partial_store && !state);
    assign data_req.write = active && state && is_store;
    assign data_req.writedata = store_data;

    // next delay slot target
    assign branch_offset = {{14{instr.low.imm[15]}}, instr.low.imm, 2'b00};

    always_comb begin
        if (branch_taken) begin
            next_delay_slot = delay_slot + branch_offset;
        end else if (is_jump_imm) begin
            next_delay_slot = {delay_slot[31:28], instr_readdata[25:0], 2'b00};
        end else if (is_jr || is_jalr) begin
            next_delay_slot = reg_a_data;
        end else begin
            next_delay_slot = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
            delay_slot <= reset_vector + 32'd4;
            state <= 1'b0;
            active <= 1'b1;
            hi_reg <= 32'b0;
            lo_reg <= 32'b0;
        end else if (clk_enable && active) begin
            // jr $0 has reached the delay slot
            if (delay_slot == 32'b0) begin
                active <= 1'b0;
            end
            if (!state) begin
                state <= 1'b1;
            end else begin
                state <= 1'b0;
                pc <= delay_slot;
                delay_slot <= next_delay_slot;
                if (is_mult) begin
                    hi_reg <= mul_hi;
                    lo_reg <= mul_lo;
                end
            end
        end
    end

    assign instr_address = pc;

endmodule

// File: verilog/mips_system.sv
`timescale 1ns/10ps

module mips_system import mips_pkg::*; (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic prog_write,
    input logic [31:0] prog_addr,
    input logic [31:0] prog_data,
    output logic active,
    output logic [31:0] register_v0
);

    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] imem_address;
    logic [31:0] data_readdata;
    mem_req_t data_req;

    // loader owns the instruction memory while in reset
    assign imem_address = reset ? prog_addr : instr_address;

    mips_cpu_harvard cpu (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .instr_readdata(instr_readdata),
        .data_readdata(data_readdata),
        .active(active),
        .register_v0(register_v0),
        .instr_address(instr_address),
        .data_req(data_req)
    );

    // program contents must survive reset
    harvard_memory #(
        .depth(imem_words)
    ) instr_mem (
        .clk(clk),
        .reset(1'b0),
        .enable(reset),
        .address(imem_address),
        .write(prog_write),
        .writedata(prog_data),
        .readdata(instr_readdata)
    );

    harvard_memory #(
        .depth(dmem_words)
    ) data_mem (
        .clk(clk),
        .reset(reset),
        .enable(clk_enable),
        .address(data_req.address),
        .write(data_req.write),
        .writedata(data_req.writedata),
        .readdata(data_readdata)
    );

endmodule

// File: tb/mips_system_sva.sv
`timescale 1ns/10ps

module mips_system_sva (
    input logic clk,
    input logic reset,
    input logic clk_enable,
    input logic active,
    input logic data_read,
    input logic data_write,
    input logic [31:0] zero_reg
);

    int fail_count = 0;

    // fetch/execute model, flips on every enabled cycle of a running core
    logic exec_phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            exec_phase <= 1'b0;
        end else if (clk_enable && active) begin
            exec_phase <= ~exec_phase;
        end
    end

    // stores land only in the execute phase
    write_in_execute: assert property (@(posedge clk) disable iff (reset)
        data_write |-> exec_phase)
    else begin
        $error("data write raised in the fetch state");
        fail_count++;
    end

    // a data cycle either reads or writes
    read_write_apart: assert property (@(posedge clk) disable iff (reset)
        !(data_read && data_write))
    else begin
        $error("data read and data write raised in the same cycle");
        fail_count++;
    end

    // $zero is hardwired
    no_zero_write: assert property (@(posedge clk) disable iff (reset)
        zero_reg == 32'b0)
    else begin
        $error("register zero holds a nonzero value");
        fail_count++;
    end

    // halt is sticky until the next reset
    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
    else begin
        $error("active rose again after the halt");
        fail_count++;
    end

endmodule

// File: tb/mips_system_tb.sv
`timescale 1ns/10ps

module mips_system_tb import mips_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int timeout_cycles = 2000;
    localparam int hold_cycles = 20;
    localparam logic [4:0] t0 = 5'd8;
    localparam logic [4:0] t1 = 5'd9;
    localparam logic [4:0] t2 = 5'd10;
    localparam logic [4:0] t3 = 5'd11;
    localparam logic [4:0] t4 = 5'd12;
    localparam logic [4:0] t5 = 5'd13;
    localparam logic [4:0] t6 = 5'd14;

    logic clk;
    logic reset;
    logic clk_enable;
    logic prog_write;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic active;
    logic [31:0] register_v0;

    logic [31:0] program_words [$];
    logic check_valid;
    logic [31:0] check_expected;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int assert_failures;

    mips_system uut (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .prog_write(prog_write),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .active(active),
        .register_v0(register_v0)
    );

    bind mips_cpu_harvard mips_system_sva checks (
        .clk(clk),
        .reset(reset),
        .clk_enable(clk_enable),
        .active(active),
        .data_read(data_req.read),
        .data_write(data_req.write),
        .zero_reg(regfile.regs[0])
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] encode_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                             logic [4:0] shamt, logic [5:0] funct);
        return {op_special, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encode_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // target keeps only the bits a j-format word can carry
    function automatic logic [31:0] encode_j(logic [5:0] op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] expected_v0(int test, logic [31:0] a, logic [31:0] b);
        logic [63:0] sprod;
        logic [63:0] uprod;
        logic [31:0] word;
        logic [31:0] slt_bit;
        logic [31:0] result;
        result = 32'b0;
        case (test)
            1, 6: begin
                slt_bit = {31'b0, $signed(a) < $signed(b)};
                result = (a + b) ^ (a - b) ^ (a ^ b) ^ slt_bit ^ (a >> 3);
            end
            2: begin
                sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                uprod = {32'b0, a} * {32'b0, b};
                result = sprod[63:32] ^ sprod[31:0] ^ uprod[63:32] ^ uprod[31:0];
            end
            3: begin
                // sw of lui value, then sb to byte 0 and sh to bytes 2..3, big-endian
                word = {a[31:16], 16'h0000};
                word[31:24] = b[7:0];
                word[15:0] = b[15:0];
                // lw 0x10, lb 0x11, lbu 0x10, lh 0x12, lhu 0x10
                result = word + {{24{word[23]}}, word[23:16]} + {24'b0, word[31:24]} +
                         {{16{word[15]}}, word[15:0]} + {16'b0, word[31:16]};
            end
            4: begin
                // first addiu, two delay slots, fall-through, last delay slot
                result = 32'd5;
            end
            5: begin
                // jal at word 0 and jalr at word 4 each link to their address plus 8
                result = (reset_vector + 32'd8) + (reset_vector + 32'd24);
            end
            default: result = 32'b0;
        endcase
        return result;
    endfunction

    task automatic build_program(input int test, input logic [31:0] a, input logic [31:0] b);
        program_words.delete();
        case (test)
            1, 6: begin
                program_words.push_back(encode_i(op_lui, 5'd0, t0, a[31:16]));
                program_words.push_back(encode_i(op_ori, t0, t0, a[15:0]));
                program_words.push_back(encode_i(op_lui, 5'd0, t1, b[31:16]));
                program_words.push_back(encode_i(op_ori, t1, t1, b[15:0]));
                program_words.push_back(encode_r(t0, t1, t2, 5'd0, fn_add));
                program_words.push_back(encode_r(t0, t1, t3, 5'd0, fn_sub));
                program_words.push_back(encode_r(t0, t1, t4, 5'd0, fn_xor));
                program_words.push_back(encode_r(t0, t1, t5, 5'd0, fn_slt));
                program_words.push_back(encode_r(5'd0, t0, t6, 5'd3, fn_srl));
                program_words.push_back(encode_r(t2, t3, reg_v0, 5'd0, fn_xor));
                program_words.push_back(encode_r(reg_v0, t4, reg_v0, 5'd0, fn_xor));
                program_words.push_back(encode_r(reg_v0, t5, reg_v0, 5'd0, fn_xor));
                program_words.push_back(encode_r(reg_v0, t6, reg_v0, 5'd0, fn_xor));
            end
            2: begin
                program_words.push_back(encode_i(op_lui, 5'd0, t0, a[31:16]));
                program_words.push_back(encode_i(op_ori, t0, t0, a[15:0]));
                program_words.push_back(encode_i(op_lui, 5'd0, t1, b[31:16]));
                program_words.push_back(encode_i(op_ori, t1, t1, b[15:0]));
                program_words.push_back(encode_r(t0, t1, 5'd0, 5'd0, fn_mult));
                program_words.push_back(encode_r(5'd0, 5'd0, t2, 5'd0, fn_mfhi));
                program_words.push_back(encode_r(5'd0, 5'd0, t3, 5'd0, fn_mflo));
                program_words.push_back(encode_r(t0, t1, 5'd0, 5'd0, fn_multu));
                program_words.push_back(encode_r(5'd0, 5'd0, t4, 5'd0, fn_mfhi));
                program_words.push_back(encode_r(5'd0, 5'd0, t5, 5'd0, fn_mflo));
                program_words.push_back(encode_r(t2, t3, reg_v0, 5'd0, fn_xor));
                program_words.push_back(encode_r(reg_v0, t4, reg_v0, 5'd0, fn_xor));
                program_words.push_back(encode_r(reg_v0, t5, reg_v0, 5'd0, fn_xor));
            end
            3: begin
                program_words.push_back(encode_i(op_lui, 5'd0, t0, a[31:16]));
                program_words.push_back(encode_i(op_sw, 5'd0, t0, 16'h0010));
                program_words.push_back(encode_i(op_ori, 5'd0, t1, b[15:0]));
                program_words.push_back(encode_i(op_sb, 5'd0, t1, 16'h0010));
                program_words.push_back(encode_i(op_sh, 5'd0, t1, 16'h0012));
                program_words.push_back(encode_i(op_lw, 5'd0, reg_v0, 16'h0010));
                program_words.push_back(encode_i(op_lb, 5'd0, t3, 16'h0011));
                program_words.push_back(encode_i(op_lbu, 5'd0, t4, 16'h0010));
                program_words.push_back(encode_i(op_lh, 5'd0, t5, 16'h0012));
                program_words.push_back(encode_i(op_lhu, 5'd0, t6, 16'h0010));
                program_words.push_back(encode_r(reg_v0, t3, reg_v0, 5'd0, fn_add));
                program_words.push_back(encode_r(reg_v0, t4, reg_v0, 5'd0, fn_add));
                program_words.push_back(encode_r(reg_v0, t5, reg_v0, 5'd0, fn_add));
                program_words.push_back(encode_r(reg_v0, t6, reg_v0, 5'd0, fn_add));
            end
            4: begin
                program_words.push_back(encode_i(op_addiu, 5'd0, reg_v0, 16'd1));
                program_words.push_back(encode_i(op_beq, 5'd0, 5'd0, 16'd2));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd1));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd100));
                program_words.push_back(encode_i(op_bne, 5'd0, 5'd0, 16'd5));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd1));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd1));
                program_words.push_back(encode_i(op_bne, reg_v0, 5'd0, 16'd2));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd1));
                program_words.push_back(encode_i(op_addiu, reg_v0, reg_v0, 16'd100));
            end
            5: begin
                program_words.push_back(encode_j(op_jal, reset_vector + 32'd12));
                program_words.push_back(32'h0000_0000);
                program_words.push_back(encode_i(op_addiu, reg_ra, reg_ra, 16'd1));
                program_words.push_back(encode_i(op_addiu, reg_ra, t0, 16'd20));
                program_words.push_back(encode_r(t0, 5'd0, t1, 5'd0, fn_jalr));
                program_words.push_back(32'h0000_0000);
                program_words.push_back(encode_i(op_addiu, t1, t1, 16'd1));
                program_words.push_back(encode_r(reg_ra, t1, reg_v0, 5'd0, fn_add));
            end
            default: ;
        endcase
        // jr $0 then a nop in its delay slot halts the core
        program_words.push_back(encode_r(5'd0, 5'd0, 5'd0, 5'd0, fn_jr));
        program_words.push_back(32'h0000_0000);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
            test_errors++;
        end
    endtask

    // compare process, samples v0 once the core has halted
    always @(posedge clk) begin
        if (check_valid) begin
            check_equal("register_v0", register_v0, check_expected);
        end
    end

    task automatic run_test(input int test, input string name, input logic gated);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        int cycles;
        a = $urandom;
        b = $urandom;
        build_program(test, a, b);
        test_errors = 0;
        @(negedge clk);
        reset = 1'b1;
        clk_enable = 1'b1;
        // instruction memory is written only while reset is high
        for (int i = 0; i < reset_cycles; i++) begin
            prog_addr = reset_vector + 32'(4 * i);
            if (i < program_words.size()) begin
                prog_write = 1'b1;
                prog_data = program_words[i];
            end else begin
                prog_write = 1'b0;
                prog_data = 32'b0;
            end
            @(negedge clk);
        end
        reset = 1'b0;
        prog_write = 1'b0;
        cycles = 0;
        while (active && cycles < timeout_cycles) begin
            if (gated) begin
                rnd = $urandom;
                clk_enable = rnd[0];
            end
            @(negedge clk);
            cycles++;
        end
        clk_enable = 1'b1;
        if (active) begin
            $display("test %0d %s: core did not halt within %0d cycles",
                     test, name, timeout_cycles);
            test_errors++;
        end else begin
            check_expected = expected_v0(test, a, b);
            check_valid = 1'b1;
            @(negedge clk);
            check_valid = 1'b0;
            if (test == 6) begin
                // halted core must stay put
                for (int i = 0; i < hold_cycles; i++) begin
                    @(negedge clk);
                    check_equal("active", {31'b0, active}, 32'd0);
                    check_equal("register_v0", register_v0, check_expected);
                end
            end
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", test, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test, name, test_errors);
        end
    endtask

    initial begin
        void'($urandom(32'he866_df71));
        reset = 1'b1;
        clk_enable = 1'b1;
        prog_write = 1'b0;
        prog_addr = 32'b0;
        prog_data = 32'b0;
        check_valid = 1'b0;
        check_expected = 32'b0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        run_test(1, "alu and immediates", 1'b0);
        run_test(2, "multiply", 1'b0);
        run_test(3, "stores and loads", 1'b0);
        run_test(4, "branches and delay slot", 1'b0);
        run_test(5, "links", 1'b0);
        run_test(6, "clock enable and halt", 1'b1);
        assert_failures = uut.cpu.checks.fail_count;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_failures);
        if (tests_failed == 0 && assert_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: mips_system.f
verilog/mips_pkg.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_load_store.sv
verilog/harvard_memory.sv
verilog/mips_cpu_harvard.sv
verilog/mips_system.sv
tb/mips_system_sva.sv
tb/mips_system_tb.sv

// File: Makefile
VERILATOR = verilator
TOP = mips_system_tb
RTL_TOP = mips_system
FILELIST = mips_system.f
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR = obj_dir
LOG = sim.log
RUN_ARGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
